//--- logic/memPkg.sv
package memPkg;

    // byte address into the RAM space
    typedef logic [31:0] addrT;

    // data or instruction word
    typedef logic [31:0] wordT;

    // one RAM byte
    typedef logic [7:0] byteT;

    // access length in bytes, only 1, 2 or 4 are legal
    typedef logic [2:0] lenT;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } accessT;

    // data port request, 68 bits
    typedef struct packed {
        accessT kind;
        lenT    len;
        addrT   addr;
        wordT   wdata;
    } dataReqT;

    // instruction fetch always moves a whole word
    localparam lenT FETCH_LEN = 3'd4;

    function automatic logic isLegalLen(lenT len);
        return (len == 3'd1) || (len == 3'd2) || (len == 3'd4);
    endfunction

endpackage

//--- logic/requestHold.sv
`timescale 1ns/1ps

module requestHold #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    req,
    input  payloadT payloadIn,
    input  logic    take,
    output logic    pending,
    output payloadT payload
);

    // pending flag, set by the strobe and cleared once the engine takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (req) begin
            pending <= 1'b1;
        end else if (take) begin
            pending <= 1'b0;
        end
    end

    // request fields stay put until the next strobe
    always_ff @(posedge clk) begin
        if (req) begin
            payload <= payloadIn;
        end
    end

    // requester must wait for busy to drop before strobing again
    reqWhilePending : assert property (
        @(posedge clk) disable iff (rst)
        req |-> (!pending || take)
    );

endmodule

//--- logic/transferEngine.sv
`timescale 1ns/1ps

module transferEngine (
    input  logic            clk,
    input  logic            rst,
    input  logic            ioFull,
    input  logic            fetchPending,
    input  memPkg::addrT    fetchAddr,
    input  logic            dataPending,
    input  memPkg::dataReqT dataReq,
    output logic            fetchTake,
    output logic            dataTake,
    output memPkg::addrT    ramAddr,
    output logic            ramWe,
    output memPkg::byteT    ramWdata,
    input  memPkg::byteT    ramRdata,
    output logic            fetchDone,
    output memPkg::wordT    fetchInst,
    output logic            dataDone,
    output memPkg::wordT    dataRdata,
    output logic            servingFetch,
    output logic            servingData
);
    import memPkg::*;

    // transaction control
    logic   active;
    logic   curData;
    lenT    stage;
    logic   fetchDoneQ;
    logic   dataDoneQ;

    // latched request
    accessT curKind;
    lenT    curLen;
    addrT   baseAddr;
    wordT   curWdata;

    // load assembly
    wordT   asmWord;
    wordT   merged;
    wordT   result;

    logic   grantOk;
    logic   dataGrant;
    logic   fetchGrant;
    logic   advance;
    logic   storeLast;
    logic   loadLast;
    logic   finish;
    logic   finishData;

    accessT nowKind;
    lenT    nowLen;
    addrT   nowAddr;
    wordT   nowWdata;
    lenT    stageNext;
    lenT    prevStage;
    lenT    offset;

    // done cycle doubles as the idle gap before the next grant
    assign grantOk    = !active && !fetchDoneQ && !dataDoneQ && !ioFull;
    assign dataGrant  = grantOk && dataPending;
    assign fetchGrant = grantOk && fetchPending && !dataPending;
    assign dataTake   = dataGrant;
    assign fetchTake  = fetchGrant;
    assign advance    = dataGrant || fetchGrant || active;

    // request seen this cycle: straight from the holder while granting
    always_comb begin
        if (active) begin
            nowKind  = curKind;
            nowLen   = curLen;
            nowAddr  = baseAddr;
            nowWdata = curWdata;
        end else if (dataPending) begin
            nowKind  = dataReq.kind;
            nowLen   = dataReq.len;
            nowAddr  = dataReq.addr;
            nowWdata = dataReq.wdata;
        end else begin
            nowKind  = LOAD;
            nowLen   = FETCH_LEN;
            nowAddr  = fetchAddr;
            nowWdata = dataReq.wdata;
        end
    end

    assign stageNext = stage + 3'd1;
    assign prevStage = stage - 3'd1;

    // a stall re-reads the previous byte so rdata is still in step afterwards
    assign offset   = (active && ioFull) ? prevStage : stage;
    assign ramAddr  = nowAddr + addrT'(offset);
    assign ramWdata = nowWdata[{stage[1:0], 3'b000} +: 8];
    assign ramWe    = !ioFull && (nowKind == STORE) && (dataGrant || active);

    // stores end on the last write, loads one cycle later on the last return
    assign storeLast  = (nowKind == STORE) && (stageNext == nowLen);
    assign loadLast   = active && (curKind == LOAD) && (stage == curLen);
    assign finish     = advance && (storeLast || loadLast);
    assign finishData = active ? curData : dataGrant;

    // byte returned now belongs to the address of the previous stage
    always_comb begin
        merged = asmWord;
        merged[{prevStage[1:0], 3'b000} +: 8] = ramRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            curData    <= 1'b0;
            stage      <= '0;
            fetchDoneQ <= 1'b0;
            dataDoneQ  <= 1'b0;
        end else if (!ioFull) begin
            fetchDoneQ <= finish && !finishData;
            dataDoneQ  <= finish && finishData;
            if (finish) begin
                active <= 1'b0;
                stage  <= '0;
            end else if (advance) begin
                active <= 1'b1;
                stage  <= stageNext;
            end
            if (dataGrant || fetchGrant) begin
                curData <= dataGrant;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ioFull) begin
            if (dataGrant || fetchGrant) begin
                curKind  <= nowKind;
                curLen   <= nowLen;
                baseAddr <= nowAddr;
                curWdata <= nowWdata;
                // cleared so short loads come out zero-extended
                asmWord  <= '0;
            end else if (active && (curKind == LOAD)) begin
                asmWord <= merged;
            end
            if (finish) begin
                result <= (nowKind == LOAD) ? merged : '0;
            end
        end
    end

    // done held through a stall, shown once it lifts
    assign fetchDone    = fetchDoneQ && !ioFull;
    assign dataDone     = dataDoneQ && !ioFull;
    assign fetchInst    = result;
    assign dataRdata    = result;
    assign servingFetch = active && !curData;
    assign servingData  = active && curData;

    dataLenLegal : assert property (
        @(posedge clk) disable iff (rst)
        dataPending |-> isLegalLen(dataReq.len)
    );

    // a done strobe is followed by at least one quiet cycle
    doneSingle : assert property (
        @(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |=> !(fetchDone || dataDone)
    );

    // fetch never writes, from grant to last byte
    noFetchWrite : assert property (
        @(posedge clk) disable iff (rst)
        (fetchTake || servingFetch) |-> !ramWe
    );

endmodule

//--- logic/byteRam.sv
`timescale 1ns/1ps

module byteRam #(
    parameter int RAM_DEPTH = 4096
) (
    input  logic         clk,
    input  memPkg::addrT addr,
    input  logic         we,
    input  memPkg::byteT wdata,
    output memPkg::byteT rdata
);
    import memPkg::*;

    localparam int ADDR_W = $clog2(RAM_DEPTH);

    byteT mem [RAM_DEPTH];

    logic [ADDR_W-1:0] index;

    // upper address bits wrap onto the array
    assign index = addr[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[index];
    end

endmodule

//--- logic/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem #(
    parameter int RAM_DEPTH = 4096
) (
    input  logic           clk,
    input  logic           rst,

    input  logic           fetchReq,
    input  memPkg::addrT   fetchAddr,
    output logic           fetchDone,
    output memPkg::wordT   fetchInst,
    output logic           fetchBusy,

    input  logic           dataReq,
    input  memPkg::accessT dataKind,
    input  memPkg::lenT    dataLen,
    input  memPkg::addrT   dataAddr,
    input  memPkg::wordT   dataWdata,
    output logic           dataDone,
    output memPkg::wordT   dataRdata,
    output logic           dataBusy,

    input  logic           ioFull
);
    import memPkg::*;

    dataReqT dataIn;
    dataReqT dataHeld;
    addrT    fetchHeld;
    logic    fetchPending;
    logic    dataPending;
    logic    fetchTake;
    logic    dataTake;
    logic    servingFetch;
    logic    servingData;

    addrT    ramAddr;
    logic    ramWe;
    byteT    ramWdata;
    byteT    ramRdata;

    assign dataIn = '{kind: dataKind, len: dataLen, addr: dataAddr, wdata: dataWdata};

    requestHold #(.payloadT(addrT)) u_fetchHold (
        .clk       (clk),
        .rst       (rst),
        .req       (fetchReq),
        .payloadIn (fetchAddr),
        .take      (fetchTake),
        .pending   (fetchPending),
        .payload   (fetchHeld)
    );

    requestHold #(.payloadT(dataReqT)) u_dataHold (
        .clk       (clk),
        .rst       (rst),
        .req       (dataReq),
        .payloadIn (dataIn),
        .take      (dataTake),
        .pending   (dataPending),
        .payload   (dataHeld)
    );

    transferEngine u_engine (
        .clk          (clk),
        .rst          (rst),
        .ioFull       (ioFull),
        .fetchPending (fetchPending),
        .fetchAddr    (fetchHeld),
        .dataPending  (dataPending),
        .dataReq      (dataHeld),
        .fetchTake    (fetchTake),
        .dataTake     (dataTake),
        .ramAddr      (ramAddr),
        .ramWe        (ramWe),
        .ramWdata     (ramWdata),
        .ramRdata     (ramRdata),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .servingFetch (servingFetch),
        .servingData  (servingData)
    );

    byteRam #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    // busy from strobe until the done cycle
    assign fetchBusy = fetchPending || servingFetch;
    assign dataBusy  = dataPending || servingData;

endmodule

//--- verif/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;
    import memPkg::*;

    localparam int RAM_DEPTH = 4096;
    localparam int ADDR_W = $clog2(RAM_DEPTH);
    // about 250 transfers at up to 14 cycles each, plus margin
    localparam int MAX_CYCLES = 250 * 14 + 1500;
    // every load and fetch stays inside this window, filled first
    localparam int WIN_BASE = 'h100;
    localparam int WIN_SIZE = 64;

    logic   clk;
    logic   rst;
    logic   fetchReq;
    addrT   fetchAddr;
    logic   fetchDone;
    wordT   fetchInst;
    logic   fetchBusy;
    logic   dataReq;
    accessT dataKind;
    lenT    dataLen;
    addrT   dataAddr;
    wordT   dataWdata;
    logic   dataDone;
    wordT   dataRdata;
    logic   dataBusy;
    logic   ioFull;

    byteT    shadow [RAM_DEPTH];
    dataReqT dataOps[$];
    int      dataDue[$];
    addrT    fetchOps[$];
    int      fetchDue[$];

    int   cycle = 0;
    int   checks = 0;
    int   errors = 0;
    int   testNum = 0;
    int   testErrStart = 0;
    int   lastDataCycle = 0;
    int   lastFetchCycle = 0;
    int   spanLeft = 0;
    logic stallOn = 1'b0;

    memSubsystem #(.RAM_DEPTH(RAM_DEPTH)) u_memSubsystem (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .fetchBusy (fetchBusy),
        .dataReq   (dataReq),
        .dataKind  (dataKind),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .dataBusy  (dataBusy),
        .ioFull    (ioFull)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // little-endian, zero-extended view of the shadow bytes
    function automatic wordT expectedWord(addrT addr, lenT len);
        wordT w;
        addrT a;
        logic [ADDR_W-1:0] idx;
        int i;
        w = '0;
        for (i = 0; i < int'(len); i++) begin
            a = addr + addrT'(i);
            idx = a[ADDR_W-1:0];
            w[8*i +: 8] = shadow[idx];
        end
        return w;
    endfunction

    task automatic applyStore(addrT addr, lenT len, wordT wdata);
        addrT a;
        logic [ADDR_W-1:0] idx;
        int i;
        for (i = 0; i < int'(len); i++) begin
            a = addr + addrT'(i);
            idx = a[ADDR_W-1:0];
            shadow[idx] = wdata[8*i +: 8];
        end
    endtask

    task automatic checkWord(string name, wordT expected, wordT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkFlag(string name, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    function automatic addrT windowAddr(int off);
        return addrT'(WIN_BASE + off);
    endfunction

    // random upper bits, which the RAM ignores
    function automatic addrT aliasAddr(int off);
        addrT r;
        r = $urandom;
        return (r & ~addrT'(RAM_DEPTH - 1)) | addrT'(WIN_BASE + off);
    endfunction

    // latency 0 means the done cycle is not checked
    task automatic armData(accessT kind, lenT len, addrT addr, wordT wdata, int latency);
        dataReqT op;
        op.kind = kind;
        op.len = len;
        op.addr = addr;
        op.wdata = wdata;
        dataKind = kind;
        dataLen = len;
        dataAddr = addr;
        dataWdata = wdata;
        dataReq = 1'b1;
        dataOps.push_back(op);
        dataDue.push_back((latency == 0) ? 0 : cycle + latency);
    endtask

    task automatic armFetch(addrT addr, int latency);
        fetchAddr = addr;
        fetchReq = 1'b1;
        fetchOps.push_back(addr);
        fetchDue.push_back((latency == 0) ? 0 : cycle + latency);
    endtask

    task automatic dropStrobes();
        @(negedge clk);
        dataReq = 1'b0;
        fetchReq = 1'b0;
    endtask

    task automatic doData(accessT kind, lenT len, addrT addr, wordT wdata, int latency);
        while (dataBusy) @(negedge clk);
        armData(kind, len, addr, wdata, latency);
        dropStrobes();
    endtask

    task automatic doFetch(addrT addr, int latency);
        while (fetchBusy) @(negedge clk);
        armFetch(addr, latency);
        dropStrobes();
    endtask

    task automatic waitAllIdle();
        while (dataBusy || fetchBusy || dataOps.size() != 0 || fetchOps.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic reportTest(string name);
        testNum++;
        if (errors == testErrStart) begin
            $display("test %0d %s: ok", testNum, name);
        end else begin
            $display("test %0d %s: %0d errors", testNum, name, errors - testErrStart);
        end
        testErrStart = errors;
    endtask

    // outputs are sampled just before the edge, stable since the falling edge
    always @(posedge clk) begin : compareDone
        dataReqT op;
        addrT    fa;
        int      due;
        if (!rst) begin
            if (ioFull && (dataDone || fetchDone)) begin
                errors++;
                $display("a done strobe was high while ioFull was high at %0t", $time);
            end
            if (dataDone) begin
                if (dataOps.size() == 0) begin
                    errors++;
                    $display("dataDone at %0t with no data request outstanding", $time);
                end else begin
                    op = dataOps.pop_front();
                    due = dataDue.pop_front();
                    lastDataCycle = cycle;
                    if (due != 0 && due != cycle) begin
                        errors++;
                        $display("dataDone came in cycle %0d instead of cycle %0d", cycle, due);
                    end
                    if (op.kind == STORE) begin
                        applyStore(op.addr, op.len, op.wdata);
                    end else begin
                        checkWord("dataRdata", expectedWord(op.addr, op.len), dataRdata);
                    end
                end
            end
            if (fetchDone) begin
                if (fetchOps.size() == 0) begin
                    errors++;
                    $display("fetchDone at %0t with no fetch outstanding", $time);
                end else begin
                    fa = fetchOps.pop_front();
                    due = fetchDue.pop_front();
                    lastFetchCycle = cycle;
                    if (due != 0 && due != cycle) begin
                        errors++;
                        $display("fetchDone came in cycle %0d instead of cycle %0d", cycle, due);
                    end
                    checkWord("fetchInst", expectedWord(fa, FETCH_LEN), fetchInst);
                end
            end
        end
    end

    // alternating run and stall spans of random length
    always @(negedge clk) begin
        if (!stallOn) begin
            ioFull = 1'b0;
            spanLeft = 0;
        end else if (spanLeft == 0) begin
            ioFull = !ioFull;
            spanLeft = ioFull ? 1 + int'($urandom % 5) : 3 + int'($urandom % 12);
        end else begin
            spanLeft = spanLeft - 1;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int     off;
        int     sel;
        lenT    len;
        accessT kind;
        void'($urandom(32'h3fa8));
        rst = 1'b1;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataKind = LOAD;
        dataLen = 3'd4;
        dataAddr = '0;
        dataWdata = '0;
        ioFull = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        checkFlag("fetchDone", 1'b0, fetchDone);
        checkFlag("dataDone", 1'b0, dataDone);
        checkFlag("fetchBusy", 1'b0, fetchBusy);
        checkFlag("dataBusy", 1'b0, dataBusy);
        reportTest("reset state");

        for (off = 0; off < WIN_SIZE; off += 4) begin
            doData(STORE, 3'd4, windowAddr(off), $urandom, 0);
        end
        waitAllIdle();
        doData(STORE, 3'd4, windowAddr('h10), $urandom, 5);
        waitAllIdle();
        doData(LOAD, 3'd4, windowAddr('h10), '0, 6);
        waitAllIdle();
        reportTest("word store and load");

        // upper wdata bytes must not reach the RAM
        doData(STORE, 3'd2, windowAddr('h31), $urandom, 0);
        doData(STORE, 3'd1, windowAddr('h34), $urandom, 0);
        for (off = 'h2e; off <= 'h35; off++) begin
            doData(LOAD, 3'd1, windowAddr(off), '0, 0);
            doData(LOAD, 3'd2, windowAddr(off), '0, 0);
        end
        waitAllIdle();
        reportTest("byte and halfword loads");

        doFetch(windowAddr('h10), 6);
        waitAllIdle();
        doFetch(windowAddr('h23), 6);
        waitAllIdle();
        reportTest("fetch");

        lastDataCycle = 0;
        lastFetchCycle = 0;
        armData(LOAD, 3'd4, windowAddr('h08), '0, 0);
        armFetch(windowAddr('h14), 0);
        dropStrobes();
        waitAllIdle();
        if (lastDataCycle == 0 || lastFetchCycle <= lastDataCycle) begin
            errors++;
            $display("data did not finish before fetch, cycles %0d and %0d",
                     lastDataCycle, lastFetchCycle);
        end
        // the fetch must see the store that won arbitration
        armData(STORE, 3'd4, windowAddr('h14), $urandom, 0);
        armFetch(windowAddr('h14), 0);
        dropStrobes();
        waitAllIdle();
        reportTest("simultaneous requests");

        stallOn <= 1'b1;
        repeat (150) begin
            sel = int'($urandom % 4);
            case ($urandom % 3)
                0: len = 3'd1;
                1: len = 3'd2;
                default: len = 3'd4;
            endcase
            kind = ($urandom % 2 == 0) ? LOAD : STORE;
            off = int'($urandom % (WIN_SIZE - 3));
            if (sel == 0) begin
                doFetch(aliasAddr(int'($urandom % (WIN_SIZE - 3))), 0);
            end else if (sel == 3) begin
                while (dataBusy || fetchBusy) @(negedge clk);
                armData(kind, len, aliasAddr(off), $urandom, 0);
                armFetch(aliasAddr(int'($urandom % (WIN_SIZE - 3))), 0);
                dropStrobes();
            end else begin
                doData(kind, len, aliasAddr(off), $urandom, 0);
            end
        end
        waitAllIdle();
        stallOn <= 1'b0;
        @(negedge clk);
        reportTest("stalled mixed traffic");

        $display("tests %0d, checks %0d, errors %0d", testNum, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/memPkg.sv
logic/requestHold.sv
logic/transferEngine.sv
logic/byteRam.sv
logic/memSubsystem.sv
verif/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        -f filelist.f \
        --top-module memSubsystemTb \
        -Mdir obj_dir \
        -o memSim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/memSim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
